// ==== Bender.yml ====
package:
  name: cavlc_tz

sources:
  - cavlc_pkg.sv
  - tz_apb_pkg.sv
  - tz_apb_regs.sv
  - heading_one_detect.sv
  - tz_ctrl.sv
  - total_zeros_decoding.sv
  - tz_result_store.sv
  - cavlc_tz_top.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_cavlc_tz.sv

// ==== cavlc_pkg.sv ====
//--------------------------------------
// CAVLC residual syntax definitions for the
// total_zeros decoder. Block types, sequencer
// states and coefficient counts
//--------------------------------------
package cavlc_pkg;

	// Bitstream window and coefficient counts
	localparam int window_width  = 16;
	localparam int chroma_dc_max = 4;
	localparam int ac_max        = 15;
	localparam int full_max      = 16;

	// Residual block being parsed
	typedef enum logic [3:0] {
		intra16x16_dc = 4'd0,
		intra16x16_ac = 4'd1,
		luma          = 4'd2,
		chroma_dc_cb  = 4'd3,
		chroma_dc_cr  = 4'd4,
		chroma_ac_cb  = 4'd5,
		chroma_ac_cr  = 4'd6
	} residual_state_t;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_lookup = 2'd1,
		st_done   = 2'd2
	} decoder_state_t;

	typedef logic [4:0] max_coeff_t;
	typedef logic [3:0] total_coeff_t;
	typedef logic [3:0] tz_val_t;
	typedef logic [3:0] tz_len_t;

	// Zeros ahead of the first one bit
	typedef logic [3:0] lz_pos_t;

endpackage

// ==== cavlc_tz_top.sv ====
//--------------------------------------
// total_zeros decoder subsystem behind an
// APB slave port
//--------------------------------------
`timescale 1ns/100ps

module cavlc_tz_top (
	input  logic                                    clk,
	input  logic                                    reset_n,
	input  logic                                    psel,
	input  logic                                    penable,
	input  logic                                    pwrite,
	input  tz_apb_pkg::apb_word_t                   paddr,
	input  tz_apb_pkg::apb_word_t                   pwdata,
	input  logic [tz_apb_pkg::apb_data_width/8-1:0] pstrb,
	output tz_apb_pkg::apb_word_t                   prdata,
	output logic                                    pready,
	output logic                                    pslverr
);
	import cavlc_pkg::*;

	residual_state_t         block_type;
	total_coeff_t            total_coeff;
	logic [window_width-1:0] window;
	logic                    start;
	logic                    clear;
	lz_pos_t                 lz_pos;
	decoder_state_t          decoder_state;
	logic                    capture;
	logic                    busy;
	tz_val_t                 total_zeros;
	tz_len_t                 total_zeros_len;
	tz_val_t                 result_zeros;
	tz_len_t                 result_len;
	logic [7:0]              consumed;
	logic                    valid;
	logic                    error;

	// Input side
	tz_apb_regs tz_apb_regs_inst (
		.clk(clk), .reset_n(reset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.busy(busy), .result_zeros(result_zeros), .result_len(result_len),
		.consumed(consumed), .valid(valid), .error(error),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.block_type(block_type), .total_coeff(total_coeff), .window(window),
		.start(start), .clear(clear)
	);

	// Processing
	heading_one_detect heading_one_detect_inst (
		.window(window), .lz_pos(lz_pos)
	);

	tz_ctrl tz_ctrl_inst (
		.clk(clk), .reset_n(reset_n), .start(start),
		.decoder_state(decoder_state), .capture(capture), .busy(busy)
	);

	total_zeros_decoding total_zeros_decoding_inst (
		.clk(clk), .reset_n(reset_n),
		.residual_state(block_type), .decoder_state(decoder_state),
		.total_coeff(total_coeff), .lz_pos(lz_pos), .window(window),
		.total_zeros(total_zeros), .total_zeros_len(total_zeros_len)
	);

	// Output side
	tz_result_store tz_result_store_inst (
		.clk(clk), .reset_n(reset_n), .capture(capture), .clear(clear),
		.total_zeros(total_zeros), .total_zeros_len(total_zeros_len),
		.result_zeros(result_zeros), .result_len(result_len),
		.consumed(consumed), .valid(valid), .error(error)
	);

endmodule

// ==== flist.f ====
cavlc_pkg.sv
tz_apb_pkg.sv
tz_apb_regs.sv
heading_one_detect.sv
tz_ctrl.sv
total_zeros_decoding.sv
tz_result_store.sv
cavlc_tz_top.sv
tb_clock_gen.sv
tb_cavlc_tz.sv

// ==== heading_one_detect.sv ====
//--------------------------------------
// Leading zero count of the bitstream window.
// The count picks the prefix class of every
// total_zeros codeword
//--------------------------------------
`timescale 1ns/100ps

module heading_one_detect (
	input  logic [cavlc_pkg::window_width-1:0] window,
	output cavlc_pkg::lz_pos_t                 lz_pos
);
	import cavlc_pkg::*;

	// Lower bits run first so the highest one bit wins.
	// Bit 0 alone and an empty window both saturate at 15
	always_comb
	begin
		lz_pos = lz_pos_t'(window_width - 1);
		for (int i = 0; i < window_width - 1; i++)
		begin
			if (window[i + 1])
				lz_pos = lz_pos_t'(window_width - 2 - i);
		end
	end

endmodule

// ==== tb_cavlc_tz.sv ====
//----------------------------------------
// Directed testbench for the total_zeros
// decoder. Drives APB transfers and checks
// the decoded words against the tables
//----------------------------------------
`timescale 1ns/100ps

module tb_cavlc_tz;
	import cavlc_pkg::*;
	import tz_apb_pkg::*;

	localparam int n_luma   = 16;
	localparam int n_chroma = 9;

	logic       clk;
	logic       reset_n;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_word_t  paddr;
	apb_word_t  pwdata;
	logic [3:0] pstrb;
	apb_word_t  prdata;
	logic       pready;
	logic       pslverr;

	integer seed = 32'ha4ea;
	int     errors;
	int     test_errors;
	int     tests_run;
	int     tests_failed;

	// Tables 9-7 and 9-8, codewords right aligned
	total_coeff_t luma_tc [n_luma] = '{4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd2, 4'd2, 4'd3,
		4'd3, 4'd3, 4'd8, 4'd8, 4'd10, 4'd12, 4'd15, 4'd15};
	logic [8:0] luma_code [n_luma] = '{9'b1, 9'b011, 9'b00010, 9'b000000001, 9'b101,
		9'b0101, 9'b000010, 9'b0101, 9'b100, 9'b00001, 9'b0001, 9'b11, 9'b00001, 9'b1,
		9'b1, 9'b0};
	tz_len_t luma_len [n_luma] = '{4'd1, 4'd3, 4'd5, 4'd9, 4'd3, 4'd4, 4'd6, 4'd4,
		4'd3, 4'd5, 4'd4, 4'd2, 4'd5, 4'd1, 4'd1, 4'd1};
	tz_val_t luma_tz [n_luma] = '{4'd0, 4'd1, 4'd6, 4'd15, 4'd2, 4'd5, 4'd12, 4'd0,
		4'd6, 4'd12, 4'd1, 4'd4, 4'd0, 4'd3, 4'd1, 4'd0};

	// Table 9-9, chroma DC
	total_coeff_t cdc_tc [n_chroma] = '{4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd2, 4'd2, 4'd3,
		4'd3};
	logic [8:0] cdc_code [n_chroma] = '{9'b1, 9'b01, 9'b001, 9'b000, 9'b1, 9'b01, 9'b00,
		9'b1, 9'b0};
	tz_len_t cdc_len [n_chroma] = '{4'd1, 4'd2, 4'd3, 4'd3, 4'd1, 4'd2, 4'd2, 4'd1, 4'd1};
	tz_val_t cdc_tz [n_chroma] = '{4'd0, 4'd1, 4'd2, 4'd3, 4'd0, 4'd1, 4'd2, 4'd0, 4'd1};

	tb_clock_gen tb_clock_gen_inst (
		.clk(clk), .reset_n(reset_n)
	);

	cavlc_tz_top cavlc_tz_top_inst (
		.clk(clk), .reset_n(reset_n),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
		.prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	//----------------------------------------
	// Compare tasks
	//----------------------------------------
	task automatic check_zeros(input string name, input tz_val_t got, input tz_val_t exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_len(input string name, input tz_len_t got, input tz_len_t exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_count(input string name, input logic [7:0] got,
		input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("error: %s got %h expected %h", name, got, exp);
			test_errors++;
		end
	endtask

	//----------------------------------------
	// APB transfers
	//----------------------------------------
	// Repeated writes go back to back with no idle cycle
	task automatic apb_write(input apb_word_t addr, input apb_word_t data, input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge clk);
			psel    <= 1'b1;
			penable <= 1'b0;
			pwrite  <= 1'b1;
			paddr   <= addr;
			pwdata  <= data;
			pstrb   <= 4'hf;
			@(posedge clk);
			penable <= 1'b1;
			@(negedge clk);
			check_flag("pready", pready, 1'b1);
		end
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_word_t addr, output apb_word_t data, output logic err);
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		check_flag("pready", pready, 1'b1);
		data = prdata;
		err  = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic wait_valid();
		apb_word_t st;
		logic      err;
		logic      ok;
		ok = 1'b0;
		for (int n = 0; n < 20 && !ok; n++)
		begin
			apb_read(reg_status, st, err);
			ok = st[status_valid_bit] && !st[status_busy_bit];
		end
		if (!ok)
		begin
			$display("timeout: no valid result after start");
			test_errors++;
		end
	endtask

	function automatic apb_word_t ctrl_word(input residual_state_t bt,
		input total_coeff_t tc, input logic go, input logic clr);
		apb_word_t w;
		w = '0;
		w[ctrl_start_bit]     = go;
		w[ctrl_clear_bit]     = clr;
		w[ctrl_type_lsb +: 4] = bt;
		w[ctrl_tc_lsb +: 4]   = tc;
		return w;
	endfunction

	// Codeword at the top, random bits below it
	task automatic place_code(input logic [8:0] code, input tz_len_t len,
		output logic [15:0] win);
		logic [15:0] tail;
		tail = $random(seed);
		win  = ({7'h0, code} << (16 - len)) | (tail & (16'hffff >> len));
	endtask

	task automatic check_decode(input residual_state_t bt, input total_coeff_t tc,
		input logic [15:0] win, input tz_val_t tz, input tz_len_t len, input logic bad);
		apb_word_t result;
		apb_word_t status;
		logic      err;
		apb_write(reg_window, {16'h0, win}, 1);
		apb_write(reg_ctrl, ctrl_word(bt, tc, 1'b1, 1'b0), 1);
		wait_valid();
		apb_read(reg_result, result, err);
		apb_read(reg_status, status, err);
		if (!bad)
			check_zeros("total_zeros", result[result_tz_lsb +: 4], tz);
		check_len("total_zeros_len", result[result_len_lsb +: 4], len);
		check_flag("error", status[status_error_bit], bad);
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (test_errors == 0)
			$display("test %s: ok", name);
		else
		begin
			$display("test %s: %0d errors", name, test_errors);
			tests_failed++;
		end
		errors      += test_errors;
		test_errors  = 0;
	endtask

	//----------------------------------------
	// Tests
	//----------------------------------------
	task automatic test_luma();
		logic [15:0] win;
		for (int i = 0; i < n_luma; i++)
		begin
			place_code(luma_code[i], luma_len[i], win);
			check_decode(luma, luma_tc[i], win, luma_tz[i], luma_len[i], 1'b0);
		end
		finish_test("luma vectors");
	endtask

	task automatic test_chroma_dc();
		logic [15:0] win;
		logic [15:0] tail;
		for (int i = 0; i < n_chroma; i++)
		begin
			place_code(cdc_code[i], cdc_len[i], win);
			check_decode(chroma_dc_cb, cdc_tc[i], win, cdc_tz[i], cdc_len[i], 1'b0);
		end
		// 1 01 is tz 0 in Table 9-9 but 101 is tz 2 in Table 9-7
		tail = $random(seed);
		win  = {3'b101, tail[12:0]};
		check_decode(chroma_dc_cb, 4'd2, win, 4'd0, 4'd1, 1'b0);
		check_decode(luma, 4'd2, win, 4'd2, 4'd3, 1'b0);
		finish_test("chroma dc vectors");
	endtask

	task automatic test_consumed();
		logic [15:0] win;
		logic [7:0]  sum;
		apb_word_t   word;
		logic        err;
		int          idx;
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		sum = 8'h0;
		// Enough decodes to wrap the 8-bit count
		for (int i = 0; i < 96; i++)
		begin
			idx = $unsigned($random(seed)) % n_luma;
			place_code(luma_code[idx], luma_len[idx], win);
			check_decode(luma, luma_tc[idx], win, luma_tz[idx], luma_len[idx], 1'b0);
			sum = sum + 8'(luma_len[idx]);
		end
		apb_read(reg_result, word, err);
		check_count("consumed", word[result_cnt_lsb +: 8], sum);
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		apb_read(reg_result, word, err);
		check_count("consumed", word[result_cnt_lsb +: 8], 8'h0);
		apb_read(reg_status, word, err);
		check_flag("valid", word[status_valid_bit], 1'b0);
		finish_test("consumed count");
	endtask

	task automatic test_invalid();
		logic [15:0] win;
		apb_word_t   word;
		logic        err;
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		place_code(9'b1, 4'd1, win);
		check_decode(luma, 4'd0, win, 4'd0, 4'd0, 1'b1);
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		apb_read(reg_status, word, err);
		check_flag("error", word[status_error_bit], 1'b0);
		check_decode(chroma_dc_cb, 4'd4, win, 4'd0, 4'd0, 1'b1);
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		apb_read(reg_status, word, err);
		check_flag("error", word[status_error_bit], 1'b0);
		finish_test("invalid input");
	endtask

	task automatic test_apb();
		logic [15:0] win;
		apb_word_t   word;
		logic        err;
		apb_read(32'h10, word, err);
		check_flag("pslverr", err, 1'b1);
		apb_read(reg_status, word, err);
		check_flag("pslverr", err, 1'b0);
		// Second start lands while the first decode is still busy
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b0, 1'b1), 1);
		place_code(9'b011, 4'd3, win);
		apb_write(reg_window, {16'h0, win}, 1);
		apb_write(reg_ctrl, ctrl_word(luma, 4'd1, 1'b1, 1'b0), 2);
		wait_valid();
		apb_read(reg_result, word, err);
		check_zeros("total_zeros", word[result_tz_lsb +: 4], 4'd1);
		check_len("total_zeros_len", word[result_len_lsb +: 4], 4'd3);
		check_count("consumed", word[result_cnt_lsb +: 8], 8'd3);
		// Idle with one good result held
		apb_write(reg_status, 32'hffff_ffff, 1);
		apb_read(reg_status, word, err);
		check_flag("busy", word[status_busy_bit], 1'b0);
		check_flag("valid", word[status_valid_bit], 1'b1);
		check_flag("error", word[status_error_bit], 1'b0);
		finish_test("apb behavior");
	endtask

	initial
	begin
		int n;
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		pstrb        = '0;
		errors       = 0;
		test_errors  = 0;
		tests_run    = 0;
		tests_failed = 0;
		n            = 0;
		while (reset_n !== 1'b1 && n < 50)
		begin
			@(posedge clk);
			n++;
		end
		if (reset_n !== 1'b1)
		begin
			$display("reset was never released");
			errors++;
		end
		test_luma();
		test_chroma_dc();
		test_consumed();
		test_invalid();
		test_apb();
		$display("tests run %0d, failed %0d, check errors %0d", tests_run, tests_failed,
			errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

	// Cycle limit for the whole run
	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles < 20000)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run exceeded the cycle limit");
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// ==== tb_clock_gen.sv ====
//----------------------------------------
// Testbench clock of 4 ns period and a
// reset held low for five cycles
//----------------------------------------
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk,
	output logic reset_n
);

	initial
	begin
		clk     = 1'b0;
		reset_n = 1'b0;
		repeat (5) @(posedge clk);
		reset_n <= 1'b1;
	end

	always #2 clk = ~clk;

endmodule

// ==== total_zeros_decoding.sv ====
//--------------------------------------
// total_zeros lookup from Tables 9-7, 9-8
// and 9-9. Gives the value and the codeword
// length in the lookup cycle
//--------------------------------------
`timescale 1ns/100ps

module total_zeros_decoding (
	input  logic                               clk,
	input  logic                               reset_n,
	input  cavlc_pkg::residual_state_t         residual_state,
	input  cavlc_pkg::decoder_state_t          decoder_state,
	input  cavlc_pkg::total_coeff_t            total_coeff,
	input  cavlc_pkg::lz_pos_t                 lz_pos,
	input  logic [cavlc_pkg::window_width-1:0] window,
	output cavlc_pkg::tz_val_t                 total_zeros,
	output cavlc_pkg::tz_len_t                 total_zeros_len
);
	import cavlc_pkg::*;

	max_coeff_t              max_coeff;
	logic [window_width-1:0] aligned;
	logic [1:0]              suffix;
	logic                    in_lookup;
	logic                    tc_bad;
	logic [7:0]              entry;
	tz_val_t                 tz_hold;

	function automatic tz_val_t by_suffix(input logic [1:0] bits, input tz_val_t v11,
		input tz_val_t v10, input tz_val_t v01, input tz_val_t v00);
		tz_val_t v;
		case (bits)
			2'b11: v = v11;
			2'b10: v = v10;
			2'b01: v = v01;
			default: v = v00;
		endcase
		return v;
	endfunction

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			max_coeff <= '0;
		else
			case (residual_state)
				intra16x16_dc, luma:
					max_coeff <= max_coeff_t'(full_max);
				intra16x16_ac, chroma_ac_cb, chroma_ac_cr:
					max_coeff <= max_coeff_t'(ac_max);
				chroma_dc_cb, chroma_dc_cr:
					max_coeff <= max_coeff_t'(chroma_dc_max);
				default:
					max_coeff <= '0;
			endcase
	end

	// Two bits after the leading one
	assign aligned = window << lz_pos;
	assign suffix  = aligned[window_width-2 -: 2];

	// total_zeros only follows when TotalCoeff < maxNumCoeff
	assign tc_bad    = (total_coeff == '0) || ({1'b0, total_coeff} >= max_coeff);
	assign in_lookup = (decoder_state == st_lookup);

	//--------------------------------------
	// Table rows as {value, length}
	// Index is TotalCoeff then prefix zeros
	//--------------------------------------
	always_comb
	begin
		entry = '0;
		if (max_coeff == max_coeff_t'(chroma_dc_max))
		begin
			// Table 9-9
			case ({total_coeff, lz_pos}) inside
				8'h10: entry = {4'd0, 4'd1};
				8'h11: entry = {4'd1, 4'd2};
				8'h12: entry = {4'd2, 4'd3};
				[8'h13:8'h1f]: entry = {4'd3, 4'd3};
				8'h20: entry = {4'd0, 4'd1};
				8'h21: entry = {4'd1, 4'd2};
				[8'h22:8'h2f]: entry = {4'd2, 4'd2};
				8'h30: entry = {4'd0, 4'd1};
				[8'h31:8'h3f]: entry = {4'd1, 4'd1};
				default: entry = '0;
			endcase
		end
		else
		begin
			// Tables 9-7 and 9-8
			case ({total_coeff, lz_pos}) inside
				8'h10: entry = {4'd0, 4'd1};
				[8'h11:8'h17]: entry = {(lz_pos << 1) - tz_val_t'(suffix[1]), lz_pos + 4'd2};
				8'h18: entry = {4'd15, 4'd9};
				8'h20: entry = {by_suffix(suffix, 4'd0, 4'd1, 4'd2, 4'd3), 4'd3};
				8'h21: entry = suffix[1] ? {4'd4, 4'd3} : {(suffix[0] ? 4'd5 : 4'd6), 4'd4};
				8'h22: entry = {(suffix[1] ? 4'd7 : 4'd8), 4'd4};
				8'h23: entry = {(suffix[1] ? 4'd9 : 4'd10), 4'd5};
				8'h24: entry = {(suffix[1] ? 4'd11 : 4'd12), 4'd6};
				8'h25: entry = {4'd13, 4'd6};
				[8'h26:8'h2f]: entry = {4'd14, 4'd6};
				8'h30: entry = {by_suffix(suffix, 4'd1, 4'd2, 4'd3, 4'd6), 4'd3};
				8'h31: entry = suffix[1] ? {4'd7, 4'd3} : {(suffix[0] ? 4'd0 : 4'd4), 4'd4};
				8'h32: entry = {(suffix[1] ? 4'd5 : 4'd8), 4'd4};
				8'h33: entry = {(suffix[1] ? 4'd9 : 4'd10), 4'd5};
				8'h34: entry = {4'd12, 4'd5};
				8'h35: entry = {4'd11, 4'd6};
				[8'h36:8'h3f]: entry = {4'd13, 4'd6};
				8'h40: entry = {by_suffix(suffix, 4'd1, 4'd4, 4'd5, 4'd6), 4'd3};
				8'h41: entry = suffix[1] ? {4'd8, 4'd3} : {(suffix[0] ? 4'd2 : 4'd3), 4'd4};
				8'h42: entry = {(suffix[1] ? 4'd7 : 4'd9), 4'd4};
				8'h43: entry = {(suffix[1] ? 4'd0 : 4'd10), 4'd5};
				8'h44: entry = {4'd11, 4'd5};
				[8'h45:8'h4f]: entry = {4'd12, 4'd5};
				8'h50: entry = {by_suffix(suffix, 4'd3, 4'd4, 4'd5, 4'd6), 4'd3};
				8'h51: entry = suffix[1] ? {4'd7, 4'd3} : {(suffix[0] ? 4'd0 : 4'd1), 4'd4};
				8'h52: entry = {(suffix[1] ? 4'd2 : 4'd8), 4'd4};
				8'h53: entry = {4'd10, 4'd4};
				8'h54: entry = {4'd9, 4'd5};
				[8'h55:8'h5f]: entry = {4'd11, 4'd5};
				8'h60: entry = {by_suffix(suffix, 4'd2, 4'd3, 4'd4, 4'd5), 4'd3};
				8'h61: entry = {(suffix[1] ? 4'd6 : 4'd7), 4'd3};
				8'h62: entry = {4'd9, 4'd3};
				8'h63: entry = {4'd8, 4'd4};
				8'h64: entry = {4'd1, 4'd5};
				8'h65: entry = {4'd0, 4'd6};
				[8'h66:8'h6f]: entry = {4'd10, 4'd6};
				8'h70: entry = suffix[1] ? {4'd5, 4'd2} : {(suffix[0] ? 4'd2 : 4'd3), 4'd3};
				8'h71: entry = {(suffix[1] ? 4'd4 : 4'd6), 4'd3};
				8'h72: entry = {4'd8, 4'd3};
				8'h73: entry = {4'd7, 4'd4};
				8'h74: entry = {4'd1, 4'd5};
				8'h75: entry = {4'd0, 4'd6};
				[8'h76:8'h7f]: entry = {4'd9, 4'd6};
				8'h80: entry = {(suffix[1] ? 4'd4 : 4'd5), 4'd2};
				8'h81: entry = {(suffix[1] ? 4'd3 : 4'd6), 4'd3};
				8'h82: entry = {4'd7, 4'd3};
				8'h83: entry = {4'd1, 4'd4};
				8'h84: entry = {4'd2, 4'd5};
				8'h85: entry = {4'd0, 4'd6};
				[8'h86:8'h8f]: entry = {4'd8, 4'd6};
				8'h90: entry = {(suffix[1] ? 4'd3 : 4'd4), 4'd2};
				8'h91: entry = {4'd6, 4'd2};
				8'h92: entry = {4'd5, 4'd3};
				8'h93: entry = {4'd2, 4'd4};
				8'h94: entry = {4'd7, 4'd5};
				8'h95: entry = {4'd0, 4'd6};
				[8'h96:8'h9f]: entry = {4'd1, 4'd6};
				8'ha0: entry = {(suffix[1] ? 4'd3 : 4'd4), 4'd2};
				8'ha1: entry = {4'd5, 4'd2};
				8'ha2: entry = {4'd2, 4'd3};
				8'ha3: entry = {4'd6, 4'd4};
				8'ha4: entry = {4'd0, 4'd5};
				[8'ha5:8'haf]: entry = {4'd1, 4'd5};
				8'hb0: entry = {4'd4, 4'd1};
				8'hb1: entry = {(suffix[1] ? 4'd5 : 4'd3), 4'd3};
				8'hb2: entry = {4'd2, 4'd3};
				8'hb3: entry = {4'd1, 4'd4};
				[8'hb4:8'hbf]: entry = {4'd0, 4'd4};
				8'hc0: entry = {4'd3, 4'd1};
				8'hc1: entry = {4'd2, 4'd2};
				8'hc2: entry = {4'd4, 4'd3};
				8'hc3: entry = {4'd1, 4'd4};
				[8'hc4:8'hcf]: entry = {4'd0, 4'd4};
				8'hd0: entry = {4'd2, 4'd1};
				8'hd1: entry = {4'd3, 4'd2};
				8'hd2: entry = {4'd1, 4'd3};
				[8'hd3:8'hdf]: entry = {4'd0, 4'd3};
				8'he0: entry = {4'd2, 4'd1};
				8'he1: entry = {4'd1, 4'd2};
				[8'he2:8'hef]: entry = {4'd0, 4'd2};
				8'hf0: entry = {4'd1, 4'd1};
				[8'hf1:8'hff]: entry = {4'd0, 4'd1};
				default: entry = '0;
			endcase
		end
	end

	// Value of the last lookup stays visible
	always_ff @(posedge clk)
	begin
		if (!reset_n)
			tz_hold <= '0;
		else if (in_lookup)
			tz_hold <= total_zeros;
	end

	assign total_zeros_len = (in_lookup && !tc_bad) ? entry[3:0] : '0;
	assign total_zeros     = !in_lookup ? tz_hold : (tc_bad ? '0 : entry[7:4]);

endmodule

// ==== tz_apb_pkg.sv ====
//--------------------------------------
// Register map of the total_zeros decoder
// as seen from the APB host
//--------------------------------------
package tz_apb_pkg;

	localparam int apb_data_width = 32;

	typedef logic [apb_data_width-1:0] apb_word_t;

	// Register offsets
	localparam apb_word_t reg_ctrl   = 32'h0;
	localparam apb_word_t reg_window = 32'h4;
	localparam apb_word_t reg_result = 32'h8;
	localparam apb_word_t reg_status = 32'hC;

	// reg_ctrl fields
	localparam int ctrl_start_bit = 0;
	localparam int ctrl_clear_bit = 1;
	localparam int ctrl_type_lsb  = 4;
	localparam int ctrl_tc_lsb    = 8;

	// reg_result fields
	localparam int result_tz_lsb  = 0;
	localparam int result_len_lsb = 4;
	localparam int result_cnt_lsb = 16;

	// reg_status bits
	localparam int status_busy_bit  = 0;
	localparam int status_valid_bit = 1;
	localparam int status_error_bit = 2;

endpackage

// ==== tz_apb_regs.sv ====
//--------------------------------------
// APB slave for the total_zeros decoder.
// Holds control and window registers, pulses
// start and clear, and returns result words
//--------------------------------------
`timescale 1ns/100ps

module tz_apb_regs (
	input  logic                                     clk,
	input  logic                                     reset_n,
	input  logic                                     psel,
	input  logic                                     penable,
	input  logic                                     pwrite,
	input  tz_apb_pkg::apb_word_t                    paddr,
	input  tz_apb_pkg::apb_word_t                    pwdata,
	input  logic [tz_apb_pkg::apb_data_width/8-1:0]  pstrb,
	input  logic                                     busy,
	input  cavlc_pkg::tz_val_t                       result_zeros,
	input  cavlc_pkg::tz_len_t                       result_len,
	input  logic [7:0]                               consumed,
	input  logic                                     valid,
	input  logic                                     error,
	output tz_apb_pkg::apb_word_t                    prdata,
	output logic                                     pready,
	output logic                                     pslverr,
	output cavlc_pkg::residual_state_t               block_type,
	output cavlc_pkg::total_coeff_t                  total_coeff,
	output logic [cavlc_pkg::window_width-1:0]       window,
	output logic                                     start,
	output logic                                     clear
);
	import tz_apb_pkg::*;
	import cavlc_pkg::*;

	logic access;
	logic wr_en;
	logic hit_ctrl;
	logic hit_window;
	logic hit_result;
	logic hit_status;

	assign hit_ctrl   = (paddr == reg_ctrl);
	assign hit_window = (paddr == reg_window);
	assign hit_result = (paddr == reg_result);
	assign hit_status = (paddr == reg_status);

	// Zero wait states
	assign access  = psel && penable;
	assign wr_en   = access && pwrite;
	assign pready  = access;
	assign pslverr = access && !(hit_ctrl || hit_window || hit_result || hit_status);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			block_type  <= intra16x16_dc;
			total_coeff <= '0;
			window      <= '0;
			start       <= 1'b0;
			clear       <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			clear <= 1'b0;
			if (wr_en && hit_ctrl)
			begin
				if (pstrb[ctrl_type_lsb / 8])
				begin
					start      <= pwdata[ctrl_start_bit];
					clear      <= pwdata[ctrl_clear_bit];
					block_type <= residual_state_t'(pwdata[ctrl_type_lsb +: 4]);
				end
				if (pstrb[ctrl_tc_lsb / 8])
					total_coeff <= pwdata[ctrl_tc_lsb +: 4];
			end
			if (wr_en && hit_window)
			begin
				for (int b = 0; b < window_width / 8; b++)
					if (pstrb[b])
						window[b*8 +: 8] <= pwdata[b*8 +: 8];
			end
		end
	end

	//--------------------------------------
	// Read data
	//--------------------------------------
	always_comb
	begin
		prdata = '0;
		if (hit_ctrl)
		begin
			prdata[ctrl_type_lsb +: 4] = block_type;
			prdata[ctrl_tc_lsb +: 4]   = total_coeff;
		end
		else if (hit_window)
			prdata[window_width-1:0] = window;
		else if (hit_result)
		begin
			prdata[result_tz_lsb +: 4]  = result_zeros;
			prdata[result_len_lsb +: 4] = result_len;
			prdata[result_cnt_lsb +: 8] = consumed;
		end
		else if (hit_status)
		begin
			prdata[status_busy_bit]  = busy;
			prdata[status_valid_bit] = valid;
			prdata[status_error_bit] = error;
		end
	end

endmodule

// ==== tz_ctrl.sv ====
//--------------------------------------
// Decode sequencer. One start gives one
// lookup cycle and one result capture
//--------------------------------------
`timescale 1ns/100ps

module tz_ctrl (
	input  logic                      clk,
	input  logic                      reset_n,
	input  logic                      start,
	output cavlc_pkg::decoder_state_t decoder_state,
	output logic                      capture,
	output logic                      busy
);
	import cavlc_pkg::*;

	decoder_state_t state_next;

	// Start outside idle is dropped
	always_comb
	begin
		state_next = decoder_state;
		case (decoder_state)
			st_idle:
				if (start)
					state_next = st_lookup;
			st_lookup:
				state_next = st_done;
			default:
				state_next = st_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!reset_n)
			decoder_state <= st_idle;
		else
			decoder_state <= state_next;
	end

	assign capture = (decoder_state == st_lookup);
	assign busy    = (decoder_state != st_idle);

endmodule

// ==== tz_result_store.sv ====
//--------------------------------------
// Result store. Keeps the last decode, the
// valid and error flags and the consumed bits
//--------------------------------------
`timescale 1ns/100ps

module tz_result_store (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               capture,
	input  logic               clear,
	input  cavlc_pkg::tz_val_t total_zeros,
	input  cavlc_pkg::tz_len_t total_zeros_len,
	output cavlc_pkg::tz_val_t result_zeros,
	output cavlc_pkg::tz_len_t result_len,
	output logic [7:0]         consumed,
	output logic               valid,
	output logic               error
);

	always_ff @(posedge clk)
	begin
		if (!reset_n)
		begin
			result_zeros <= '0;
			result_len   <= '0;
			consumed     <= '0;
			valid        <= 1'b0;
			error        <= 1'b0;
		end
		else
		begin
			if (capture)
			begin
				result_zeros <= total_zeros;
				result_len   <= total_zeros_len;
			end
			// Clear wins over a capture in the same cycle
			if (clear)
			begin
				consumed <= '0;
				valid    <= 1'b0;
				error    <= 1'b0;
			end
			else if (capture)
			begin
				consumed <= consumed + 8'(total_zeros_len);
				valid    <= 1'b1;
				// Zero length marks a bad decode, sticky until clear
				if (total_zeros_len == '0)
					error <= 1'b1;
			end
		end
	end

endmodule
